// File: compile.f
hw/rmt_pkg.sv
hw/sync_fifo.sv
hw/header_parser.sv
hw/match_action_stage.sv
hw/deparser.sv
hw/axil_regs.sv
hw/rmt_top.sv
sim/rmt_sva.sv
sim/rmt_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rmt_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/rmt_tb.sv
`default_nettype none

module rmt_tb import rmt_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeout_cycles = 2000;

	logic        clk = 1'b0;
	logic        aresetn = 1'b0;
	axis_beat_t  s_tbeat = '0;
	logic        s_tvalid = 1'b0;
	logic        s_tready;
	axis_beat_t  m_tbeat;
	logic        m_tvalid;
	logic        m_tready = 1'b1;
	logic [15:0] araddr = '0;
	logic        arvalid = 1'b0;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready = 1'b0;

	logic [31:0] lfsr = 32'hcc39;
	logic        bp_en = 1'b0; // random m_tready when set
	int          errors = 0;
	int          timeouts = 0;
	int          ctrl_count = 0;
	logic [31:0] last_cookie = '0;
	logic [1:0]  m_op [3];  // reference copy of each stage entry
	logic [1:0]  m_idx [3];
	logic [15:0] m_arg [3];
	axis_beat_t  tx_q [$];
	axis_beat_t  exp_q [$];

	rmt_top UUT (.*);

	bind rmt_top rmt_sva u_sva (.*);

	initial begin
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// applies stages 0 to 2 in order with 16-bit wrap
	function automatic logic [47:0] model_phv(input logic [47:0] h);
		logic [15:0] f;
		for (int s = 0; s < 3; s++) begin
			if (m_idx[s] != 2'd3) begin
				f = h[m_idx[s]*16 +: 16];
				case (m_op[s])
					2'd1: f = f + m_arg[s];
					2'd2: f = f - m_arg[s];
					2'd3: f = m_arg[s];
					default: ;
				endcase
				h[m_idx[s]*16 +: 16] = f;
			end
		end
		return h;
	endfunction

	task automatic finish_run();
		$display("summary: %0d errors, %0d timeouts, %0d beats never arrived",
			errors, timeouts, exp_q.size());
		if (errors == 0 && timeouts == 0 && exp_q.size() == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	task automatic timed_out(input string what);
		$display("timeout: no progress while %s", what);
		timeouts++;
		finish_run();
	endtask

	task automatic send_beats();
		int t;
		while (tx_q.size() != 0) begin
			@(negedge clk);
			s_tbeat  = tx_q.pop_front();
			s_tvalid = 1'b1;
			t = 0;
			while (!s_tready) begin
				t++;
				if (t > timeout_cycles)
					timed_out("waiting for s_tready");
				@(negedge clk);
			end
		end
		@(negedge clk);
		s_tvalid = 1'b0;
	endtask

	task automatic send_data(input int n);
		axis_beat_t b;
		for (int i = 0; i < n; i++) begin
			b.data = {random_bits(32), random_bits(32)};
			b.keep = (i == n - 1) ? (8'(random_bits(8)) | 8'h01) : 8'hff;
			b.last = (i == n - 1);
			if (i == 0)
				b.data[63:56] = 8'h11;
			tx_q.push_back(b);
			if (i == 0)
				b.data[47:0] = model_phv(b.data[47:0]); // fields after all stages
			exp_q.push_back(b);
		end
		send_beats();
	endtask

	task automatic send_ctrl(input logic [3:0] stage, input logic [1:0] op,
			input logic [1:0] idx, input logic [15:0] arg, input int n);
		axis_beat_t  b;
		logic [31:0] cookie;
		cookie = random_bits(32);
		b = '{data: {8'hf1, stage, op, idx, arg, cookie}, keep: 8'hff, last: (n == 1)};
		tx_q.push_back(b);
		for (int i = 1; i < n; i++) begin // extra beats dropped by the parser
			b = '{data: {random_bits(32), random_bits(32)}, keep: 8'hff, last: (i == n - 1)};
			tx_q.push_back(b);
		end
		if (stage < 4'd3) begin
			m_op[stage]  = op;
			m_idx[stage] = idx;
			m_arg[stage] = arg;
		end
		ctrl_count++;
		last_cookie = cookie;
		send_beats();
	endtask

	task automatic send_other(input logic [7:0] kind, input int n);
		axis_beat_t b;
		for (int i = 0; i < n; i++) begin
			b.data = {random_bits(32), random_bits(32)};
			if (i == 0)
				b.data[63:56] = kind;
			b.keep = 8'hff;
			b.last = (i == n - 1);
			tx_q.push_back(b);
		end
		send_beats();
	endtask

	task automatic wait_drain(input string what);
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			t++;
			if (t > timeout_cycles)
				timed_out(what);
			@(negedge clk);
		end
	endtask

	task automatic axil_read(input logic [15:0] addr, input logic [31:0] expected);
		int t;
		int hold;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		t = 0;
		while (!rvalid) begin
			t++;
			if (t > timeout_cycles)
				timed_out("waiting for rvalid");
			@(negedge clk);
		end
		assert (arready) else begin
			$display("error at %0t: arready low in the cycle rvalid rose", $time);
			errors++;
		end
		arvalid = 1'b0;
		hold = int'(random_bits(2)) + 1; // rready held back a few cycles
		repeat (hold) @(negedge clk);
		rready = 1'b1;
		assert (rvalid && rdata == expected && rresp == 2'b00) else begin
			$display("error at %0t: read of %h gave %h resp %0d valid %b, expected %h",
				$time, addr, rdata, rresp, rvalid, expected);
			errors++;
		end
		@(negedge clk);
		rready = 1'b0;
	endtask

	// compares every transferred beat in order
	always @(posedge clk) begin : check_output
		axis_beat_t e;
		if (aresetn && m_tvalid && m_tready) begin
			assert (exp_q.size() != 0) else begin
				$display("output beat %h arrived while no packet was expected", m_tbeat.data);
				errors++;
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				assert (m_tbeat == e) else begin
					$display("error at %0t: got %h/%h/%b, expected %h/%h/%b", $time,
						m_tbeat.data, m_tbeat.keep, m_tbeat.last, e.data, e.keep, e.last);
					errors++;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (bp_en)
			m_tready = (random_bits(1) != 32'd0);
		else
			m_tready = 1'b1;
	end

	task automatic reset_values();
		assert (!m_tvalid && !rvalid && s_tready) else begin
			$display("error at %0t: after reset m_tvalid %b rvalid %b s_tready %b",
				$time, m_tvalid, rvalid, s_tready);
			errors++;
		end
	endtask

	task automatic passthrough();
		for (int i = 0; i < 4; i++)
			send_data(i + 1);
		for (int i = 0; i < 4; i++)
			send_data(int'(random_bits(2)) + 1);
		wait_drain("draining pass-through packets");
	endtask

	task automatic filtering();
		send_data(2);
		send_other(8'h22, 3);
		send_ctrl(4'hf, 2'd1, 2'd0, 16'h1234, 1); // no stage has id 15
		send_data(1);
		send_ctrl(4'he, 2'd3, 2'd1, 16'h00ff, 3);
		send_other(8'h00, 1);
		send_data(3);
		wait_drain("draining around filtered packets");
	endtask

	task automatic programmed_actions();
		send_ctrl(4'd0, 2'd1, 2'd0, 16'hfff0, 1); // add that wraps often
		send_ctrl(4'd1, 2'd2, 2'd2, 16'h8001, 1); // sub
		send_ctrl(4'd2, 2'd3, 2'd1, 16'hbeef, 1); // set
		for (int i = 0; i < 8; i++)
			send_data(int'(random_bits(2)) + 1);
		send_ctrl(4'd1, 2'd1, 2'd3, 16'h5555, 1); // index 3 does nothing
		send_ctrl(4'd2, 2'd1, 2'd0, 16'h0003, 1); // stacks on stage 0
		for (int i = 0; i < 4; i++)
			send_data(int'(random_bits(2)) + 1);
		wait_drain("draining modified packets");
	endtask

	task automatic backpressure();
		bp_en = 1'b1;
		for (int i = 0; i < 12; i++)
			send_data(int'(random_bits(2)) + 1);
		wait_drain("draining under back-pressure");
		bp_en = 1'b0;
	endtask

	task automatic register_reads();
		axil_read(addr_cookie, last_cookie);
		axil_read(addr_token, 32'(ctrl_count));
		axil_read(16'h2028, 32'd0);
		axil_read(16'h0000, 32'd0);
	endtask

	initial begin
		for (int s = 0; s < 3; s++) begin
			m_op[s]  = 2'd0;
			m_idx[s] = 2'd0;
			m_arg[s] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
		reset_values();
		passthrough();
		filtering();
		programmed_actions();
		backpressure();
		register_reads();
		finish_run();
	end

endmodule

`default_nettype wire

// File: sim/rmt_sva.sv
`default_nettype none

module rmt_sva import rmt_pkg::*; (
	input logic        clk,
	input logic        aresetn,
	input axis_beat_t  m_tbeat,
	input logic        m_tvalid,
	input logic        m_tready,
	input logic        arready,
	input logic        rvalid,
	input logic        rready,
	input logic [31:0] rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	// stalled output beat must not move
	a_out_hold: assert property (@(posedge clk) disable iff (!aresetn)
		m_tvalid && !m_tready |=> m_tvalid && $stable(m_tbeat))
		else $error("output beat changed while m_tready was low");

	a_read_hold: assert property (@(posedge clk) disable iff (!aresetn)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("read data dropped or changed before rready");

	a_arready_pulse: assert property (@(posedge clk) disable iff (!aresetn)
		arready |=> !arready)
		else $error("arready held for more than one cycle");

endmodule

`default_nettype wire

// File: hw/rmt_top.sv
`default_nettype none

module rmt_top import rmt_pkg::*; (
	input  logic        clk,
	input  logic        aresetn,

	input  axis_beat_t  s_tbeat,
	input  logic        s_tvalid,
	output logic        s_tready,

	output axis_beat_t  m_tbeat,
	output logic        m_tvalid,
	input  logic        m_tready,

	input  logic [15:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	logic       pkt_wr;
	axis_beat_t pkt_wbeat;
	axis_beat_t pkt_rbeat;
	logic       pkt_rd;
	logic       pkt_empty;
	logic       pkt_nearly_full;

	phv_t       phv_out;
	logic       phv_rd;
	logic       phv_empty;

	logic        ctrl_valid;
	ctrl_wr_t    ctrl;
	logic [31:0] cookie;

	// stage i reads entry i and writes entry i+1
	logic stg_valid [num_stages+1];
	phv_t stg_phv   [num_stages+1];

	header_parser u_parser (
		.clk, .aresetn,
		.s_tbeat, .s_tvalid, .s_tready,
		.fifo_nearly_full (pkt_nearly_full),
		.fifo_wr          (pkt_wr),
		.fifo_beat        (pkt_wbeat),
		.phv_valid        (stg_valid[0]),
		.phv              (stg_phv[0]),
		.ctrl_valid, .ctrl, .cookie
	);

	for (genvar i = 0; i < num_stages; i++) begin : g_stage
		match_action_stage #(.stage_id(i)) u_stage (
			.clk, .aresetn,
			.in_valid  (stg_valid[i]),
			.in_phv    (stg_phv[i]),
			.ctrl_valid, .ctrl,
			.out_valid (stg_valid[i+1]),
			.out_phv   (stg_phv[i+1])
		);
	end

	sync_fifo #(.data_t(axis_beat_t), .depth(fifo_depth)) u_pkt_fifo (
		.clk, .aresetn,
		.wr (pkt_wr), .wdata (pkt_wbeat),
		.rd (pkt_rd), .rdata (pkt_rbeat),
		.empty (pkt_empty), .nearly_full (pkt_nearly_full)
	);

	// never overflows since every queued vector has a beat in the packet FIFO
	sync_fifo #(.data_t(phv_t), .depth(fifo_depth)) u_phv_fifo (
		.clk, .aresetn,
		.wr (stg_valid[num_stages]), .wdata (stg_phv[num_stages]),
		.rd (phv_rd), .rdata (phv_out),
		.empty (phv_empty), .nearly_full ()
	);

	deparser u_deparser (
		.clk, .aresetn,
		.pkt_beat (pkt_rbeat), .pkt_empty, .pkt_rd,
		.phv (phv_out), .phv_empty, .phv_rd,
		.m_tbeat, .m_tvalid, .m_tready
	);

	axil_regs u_regs (
		.clk, .aresetn,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.cookie_wr (ctrl_valid),
		.cookie
	);

endmodule

`default_nettype wire

// File: hw/axil_regs.sv
`default_nettype none

module axil_regs import rmt_pkg::*; (
	input  logic        clk,
	input  logic        aresetn,

	input  logic [15:0] araddr,
	input  logic        arvalid,
	output logic        arready,

	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,

	input  logic        cookie_wr,
	input  logic [31:0] cookie
);

	logic [31:0] cookie_r;
	logic [31:0] token_r;   // control writes applied
	logic [15:0] word_addr;
	logic        rd_start;

	assign word_addr = {araddr[15:2], 2'b00};
	assign rd_start  = arvalid && !rvalid;
	assign rresp     = 2'b00; // OKAY

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			cookie_r <= '0;
			token_r  <= '0;
			arready  <= 1'b0;
			rvalid   <= 1'b0;
		end else begin
			if (cookie_wr) begin
				cookie_r <= cookie;
				token_r  <= token_r + 1'b1; // wraps
			end
			arready <= rd_start;
			if (rd_start)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_start) begin
			case (word_addr)
				addr_cookie: rdata <= cookie_r;
				addr_token:  rdata <= token_r;
				default:     rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/deparser.sv
`default_nettype none

module deparser import rmt_pkg::*; (
	input  logic       clk,
	input  logic       aresetn,

	input  axis_beat_t pkt_beat,
	input  logic       pkt_empty,
	output logic       pkt_rd,

	input  phv_t       phv,
	input  logic       phv_empty,
	output logic       phv_rd,

	output axis_beat_t m_tbeat,
	output logic       m_tvalid,
	input  logic       m_tready
);

	typedef enum logic {
		wait_hdr,
		body
	} state_e;

	state_e     state;
	state_e     state_nxt;
	logic       out_free;  // output register can take a beat
	axis_beat_t merged;

	assign out_free = !m_tvalid || m_tready;

	always_comb begin
		merged            = pkt_beat;
		merged.data[47:0] = phv;
	end

	always_comb begin
		state_nxt = state;
		pkt_rd    = 1'b0;
		phv_rd    = 1'b0;
		case (state)
			wait_hdr: begin
				// first beat needs its header vector as well
				if (out_free && !pkt_empty && !phv_empty) begin
					pkt_rd = 1'b1;
					phv_rd = pkt_beat.last; // one-beat packet
					if (!pkt_beat.last)
						state_nxt = body;
				end
			end
			body: begin
				if (out_free && !pkt_empty) begin
					pkt_rd = 1'b1;
					if (pkt_beat.last) begin
						phv_rd    = 1'b1; // vector leaves with the last beat
						state_nxt = wait_hdr;
					end
				end
			end
			default: state_nxt = wait_hdr;
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state    <= wait_hdr;
			m_tvalid <= 1'b0;
		end else begin
			state <= state_nxt;
			if (out_free)
				m_tvalid <= pkt_rd;
		end
	end

	// held while the sink stalls
	always_ff @(posedge clk) begin
		if (pkt_rd)
			m_tbeat <= (state == wait_hdr) ? merged : pkt_beat;
	end

endmodule

`default_nettype wire

// File: hw/match_action_stage.sv
`default_nettype none

module match_action_stage import rmt_pkg::*; #(
	parameter int stage_id = 0
) (
	input  logic     clk,
	input  logic     aresetn,

	input  logic     in_valid,
	input  phv_t     in_phv,

	input  logic     ctrl_valid,
	input  ctrl_wr_t ctrl,

	output logic     out_valid,
	output phv_t     out_phv
);

	act_entry_t entry;
	phv_t       next_phv;

	// single action entry written by control packets for this stage
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			entry <= '{op: act_nop, idx: 2'd0, operand: '0};
		end else if (ctrl_valid && ctrl.stage == 4'(stage_id)) begin
			entry <= ctrl.entry;
		end
	end

	always_comb begin
		next_phv = in_phv;
		if (entry.idx < num_fields) begin // idx 3 leaves the vector alone
			case (entry.op)
				act_add: next_phv.field[entry.idx] = in_phv.field[entry.idx] + entry.operand;
				act_sub: next_phv.field[entry.idx] = in_phv.field[entry.idx] - entry.operand;
				act_set: next_phv.field[entry.idx] = entry.operand;
				default: next_phv = in_phv;
			endcase
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			out_phv <= next_phv;
	end

endmodule

`default_nettype wire

// File: hw/header_parser.sv
`default_nettype none

module header_parser import rmt_pkg::*; (
	input  logic       clk,
	input  logic       aresetn,

	input  axis_beat_t s_tbeat,
	input  logic       s_tvalid,
	output logic       s_tready,

	input  logic       fifo_nearly_full,
	output logic       fifo_wr,
	output axis_beat_t fifo_beat,

	output logic       phv_valid,
	output phv_t       phv,

	output logic       ctrl_valid,
	output ctrl_wr_t   ctrl,
	output logic [31:0] cookie
);

	logic accept;
	logic sop;       // next accepted beat opens a packet
	logic fwd_r;     // data flag held until tlast
	logic is_data;
	logic is_ctrl;
	logic fwd;

	assign s_tready = !fifo_nearly_full; // at least two entries free
	assign accept   = s_tvalid && s_tready;

	// kind is only looked at on the first beat
	assign is_data = (s_tbeat.data[63:56] == kind_data);
	assign is_ctrl = (s_tbeat.data[63:56] == kind_ctrl);
	assign fwd     = sop ? is_data : fwd_r;

	// data beats go straight into the packet FIFO
	assign fifo_wr   = accept && fwd;
	assign fifo_beat = s_tbeat;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			sop        <= 1'b1;
			fwd_r      <= 1'b0;
			phv_valid  <= 1'b0;
			ctrl_valid <= 1'b0;
		end else begin
			phv_valid  <= accept && sop && is_data;
			ctrl_valid <= accept && sop && is_ctrl; // later ctrl beats dropped
			if (accept) begin
				sop <= s_tbeat.last;
				if (sop)
					fwd_r <= is_data;
			end
		end
	end

	// header and control payload qualified by the strobes above
	always_ff @(posedge clk) begin
		if (accept && sop) begin
			phv    <= phv_t'(s_tbeat.data[47:0]);
			ctrl   <= ctrl_wr_t'(s_tbeat.data[55:32]);
			cookie <= s_tbeat.data[31:0];
		end
	end

endmodule

`default_nettype wire

// File: hw/sync_fifo.sv
`default_nettype none

module sync_fifo #(
	parameter type data_t = logic [7:0],
	parameter int  depth  = 4
) (
	input  logic  clk,
	input  logic  aresetn,

	input  logic  wr,
	input  data_t wdata,

	input  logic  rd,
	output data_t rdata,

	output logic  empty,
	output logic  nearly_full
);

	data_t                      mem [depth];
	logic [$clog2(depth)-1:0]   wptr;
	logic [$clog2(depth)-1:0]   rptr;
	logic [$clog2(depth+1)-1:0] count;
	logic                       wr_en;
	logic                       rd_en;

	assign wr_en = wr && (count < depth);
	assign rd_en = rd && !empty;

	assign rdata       = mem[rptr]; // first word falls through
	assign empty       = (count == 0);
	assign nearly_full = (count > depth - 2); // fewer than two free

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wptr <= (int'(wptr) == depth - 1) ? '0 : wptr + 1'b1;
			if (rd_en)
				rptr <= (int'(rptr) == depth - 1) ? '0 : rptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wptr] <= wdata;
	end

endmodule

`default_nettype wire

// File: hw/rmt_pkg.sv
`default_nettype none

package rmt_pkg;

	localparam int data_width  = 64;
	localparam int keep_width  = data_width / 8;
	localparam int field_width = 16;
	localparam int num_fields  = 3;
	localparam int num_stages  = 3;
	localparam int fifo_depth  = 16; // both FIFOs

	// word-aligned register addresses
	localparam logic [15:0] addr_cookie = 16'h2020;
	localparam logic [15:0] addr_token  = 16'h2024;

	// packet kind byte in bits 63:56 of the first beat
	typedef enum logic [7:0] {
		kind_data = 8'h11,
		kind_ctrl = 8'hf1
	} pkt_kind_e;

	typedef enum logic [1:0] {
		act_nop,
		act_add,
		act_sub,
		act_set
	} act_op_e;

	typedef struct packed {
		logic [data_width-1:0] data;
		logic [keep_width-1:0] keep;
		logic                  last;
	} axis_beat_t;

	// field[0] sits in bits 15:0 of the first beat
	typedef struct packed {
		logic [num_fields-1:0][field_width-1:0] field;
	} phv_t;

	typedef struct packed {
		act_op_e                op;
		logic [1:0]             idx; // 3 means no field
		logic [field_width-1:0] operand;
	} act_entry_t;

	// same layout as bits 55:32 of a control beat
	typedef struct packed {
		logic [3:0] stage;
		act_entry_t entry;
	} ctrl_wr_t;

endpackage

`default_nettype wire
